//--- pitch_fr3_settings.svh
`ifndef PITCH_FR3_SETTINGS_SVH
`define PITCH_FR3_SETTINGS_SVH

//////////////////////////////
// Pitch lag limits
//////////////////////////////

`define PITCH_LAG_MIN 20
`define PITCH_LAG_MAX 143

// Extra correlation values on each side of the search range
`define SEARCH_MARGIN 4

// First subframe lags above this skip the fractional search
`define EARLY_LAG_LIMIT 84

//////////////////////////////
// Interpolation filter
//////////////////////////////

`define UP_SAMP 3
`define INTER_TAPS 4

// Correlation buffer entries
`define CORR_DEPTH 160

`endif

//--- pitch_fr3_pkg.sv
package pitch_fr3_pkg;

	// Q15 normalized correlation
	typedef logic signed [15:0] corr_t;

	typedef logic [7:0] lag_t;

	// Fraction in thirds of a sample
	typedef logic signed [2:0] frac_t;

	typedef logic [7:0] index_t;

	typedef logic signed [31:0] acc_t;

	// Sequencer FSM
	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_LOAD,
		SEQ_SEARCH,
		SEQ_EARLY,
		SEQ_INTERP,
		SEQ_FOLD,
		SEQ_RESULT
	} seq_state_t;

endpackage

//--- corr_buffer.sv
`include "pitch_fr3_settings.svh"

module corr_buffer
	import pitch_fr3_pkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  logic   load_start,
	input  index_t load_len,
	input  logic   corr_valid,
	input  corr_t  corr_data,
	input  index_t rd_addr_a,
	input  index_t rd_addr_b,
	output logic   corr_ready,
	output logic   load_done,
	output corr_t  rd_data_a,
	output corr_t  rd_data_b
);

	corr_t  storage [`CORR_DEPTH];
	index_t wr_count;
	logic   loading;
	logic   beat;

	assign corr_ready = loading;
	assign beat = loading && corr_valid;

	always_ff @(posedge clock) begin
		if (reset) begin
			loading <= 1'b0;
			wr_count <= '0;
			load_done <= 1'b0;
		end else begin
			load_done <= 1'b0;
			if (load_start) begin
				loading <= 1'b1;
				wr_count <= '0;
			end else if (beat) begin
				wr_count <= wr_count + 8'd1;
				// Last beat of the stream
				if (wr_count == load_len - 8'd1) begin
					loading <= 1'b0;
					load_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (beat)
			storage[wr_count] <= corr_data;
	end

	// Two registered read ports
	always_ff @(posedge clock) begin
		rd_data_a <= storage[rd_addr_a];
		rd_data_b <= storage[rd_addr_b];
	end

endmodule

//--- integer_lag_search.sv
module integer_lag_search
	import pitch_fr3_pkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  logic   search_start,
	input  index_t first_index,
	input  index_t last_index,
	input  corr_t  rd_data,
	output index_t rd_addr,
	output logic   search_done,
	output index_t best_index
);

	index_t addr_q;
	index_t end_q;
	index_t idx_q;
	logic   busy;
	logic   rd_v;
	logic   rd_last;
	logic   seed;
	logic   fin;
	corr_t  best_val;

	assign rd_addr = addr_q;

	//////////////////////////////
	// Address walk
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			addr_q <= '0;
			end_q <= '0;
			rd_v <= 1'b0;
			rd_last <= 1'b0;
			seed <= 1'b0;
			fin <= 1'b0;
			search_done <= 1'b0;
		end else begin
			rd_v <= busy;
			rd_last <= busy && (addr_q == end_q);
			fin <= rd_v && rd_last;
			search_done <= fin;
			if (search_start) begin
				busy <= 1'b1;
				seed <= 1'b1;
				addr_q <= first_index;
				end_q <= last_index;
			end else begin
				if (busy) begin
					addr_q <= addr_q + 8'd1;
					if (addr_q == end_q)
						busy <= 1'b0;
				end
				if (rd_v)
					seed <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Running maximum
	//////////////////////////////

	// Index follows the data through the buffer latency
	always_ff @(posedge clock) begin
		idx_q <= addr_q;
		// Greater or equal so a tie moves to the later lag
		if (rd_v && (seed || rd_data >= best_val)) begin
			best_val <= rd_data;
			best_index <= idx_q;
		end
	end

endmodule

//--- frac_interpolator.sv
`include "pitch_fr3_settings.svh"

module frac_interpolator
	import pitch_fr3_pkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  logic   interp_start,
	input  index_t center_index,
	input  frac_t  frac,
	input  corr_t  rd_data,
	output index_t rd_addr,
	output logic   interp_done,
	output corr_t  interp_value
);

	localparam int taps = 2 * `INTER_TAPS;
	localparam int table_size = `UP_SAMP * `INTER_TAPS + 1;

	// 1/3 resolution filter, Q15
	localparam corr_t inter_3 [table_size] = '{
		16'sd29443,
		16'sd25207, 16'sd14701, 16'sd3143,
		-16'sd4402, -16'sd5850, -16'sd2783,
		16'sd1211, 16'sd3130, 16'sd2259,
		16'sd0, -16'sd1652, -16'sd1666
	};

	index_t     base;
	logic [1:0] phase;
	logic [2:0] step;
	logic [1:0] tap;
	logic [3:0] coef_idx;
	logic       busy;
	corr_t      coef_q;
	logic       samp_v;
	logic       samp_last;
	acc_t       mult;
	acc_t       prod_q;
	logic       prod_v;
	logic       prod_last;
	logic       fin;
	acc_t       acc;
	acc_t       rounded;

	function automatic acc_t sat_add(acc_t a, acc_t b);
		logic [32:0] s;
		s = {a[31], a} + {b[31], b};
		if (s[32] != s[31])
			return s[32] ? 32'sh8000_0000 : 32'sh7fff_ffff;
		return acc_t'(s[31:0]);
	endfunction

	//////////////////////////////
	// Tap sequencing
	//////////////////////////////

	// Even steps walk left of the center, odd steps walk right
	assign tap = step[2:1];

	always_comb begin
		if (step[0]) begin
			rd_addr = base + index_t'(tap) + 8'd1;
			coef_idx = 4'(`UP_SAMP) - 4'(phase) + 4'(tap) * 4'(`UP_SAMP);
		end else begin
			rd_addr = base - index_t'(tap);
			coef_idx = 4'(phase) + 4'(tap) * 4'(`UP_SAMP);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			step <= '0;
			samp_v <= 1'b0;
			prod_v <= 1'b0;
			fin <= 1'b0;
			interp_done <= 1'b0;
		end else begin
			samp_v <= busy;
			prod_v <= samp_v;
			fin <= prod_v && prod_last;
			interp_done <= fin;
			if (interp_start) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				step <= step + 3'd1;
				if (step == 3'(taps - 1))
					busy <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// MAC and rounding
	//////////////////////////////

	assign mult = rd_data * coef_q;
	assign rounded = sat_add(acc, 32'sh0000_8000);

	always_ff @(posedge clock) begin
		coef_q <= inter_3[coef_idx];
		samp_last <= (step == 3'(taps - 1));
		// Products are doubled like the fixed point MAC
		prod_q <= mult <<< 1;
		prod_last <= samp_last;
		if (interp_start) begin
			acc <= '0;
			// Negative fraction moves one sample left
			if (frac < 0) begin
				base <= center_index - 8'd1;
				phase <= 2'(frac + frac_t'(`UP_SAMP));
			end else begin
				base <= center_index;
				phase <= frac[1:0];
			end
		end else if (prod_v) begin
			acc <= sat_add(acc, prod_q);
		end
		if (fin)
			interp_value <= rounded[31:16];
	end

endmodule

//--- lag_sequencer.sv
`include "pitch_fr3_settings.svh"

module lag_sequencer
	import pitch_fr3_pkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  logic   cmd_valid,
	input  lag_t   t0_min,
	input  lag_t   t0_max,
	input  logic   first_subframe,
	input  logic   load_done,
	input  logic   search_done,
	input  index_t best_index,
	input  logic   interp_done,
	input  corr_t  interp_value,
	input  logic   result_ready,
	output logic   cmd_ready,
	output logic   load_start,
	output index_t load_len,
	output logic   search_start,
	output index_t first_index,
	output index_t last_index,
	output logic   interp_start,
	output index_t center_index,
	output frac_t  frac,
	output logic   result_valid,
	output lag_t   result_lag,
	output frac_t  result_frac
);

	seq_state_t state;
	lag_t       t_min_q;
	lag_t       t_max_q;
	lag_t       lag_q;
	logic       first_q;
	index_t     center_q;
	frac_t      trial;
	frac_t      best_frac;
	corr_t      best_val;

	assign cmd_ready = (state == SEQ_IDLE);
	assign result_valid = (state == SEQ_RESULT);

	// Buffer index 0 holds lag t0_min minus the margin
	assign load_len = index_t'(t_max_q - t_min_q + 2 * `SEARCH_MARGIN + 1);
	assign first_index = index_t'(`SEARCH_MARGIN);
	assign last_index = index_t'(t_max_q - t_min_q + `SEARCH_MARGIN);
	assign center_index = center_q;
	assign frac = trial;
	assign result_lag = lag_q;
	assign result_frac = best_frac;

	//////////////////////////////
	// FSM
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= SEQ_IDLE;
			load_start <= 1'b0;
			search_start <= 1'b0;
			interp_start <= 1'b0;
		end else begin
			load_start <= 1'b0;
			search_start <= 1'b0;
			interp_start <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (cmd_valid) begin
						state <= SEQ_LOAD;
						load_start <= 1'b1;
					end
				end
				SEQ_LOAD: begin
					if (load_done) begin
						state <= SEQ_SEARCH;
						search_start <= 1'b1;
					end
				end
				SEQ_SEARCH: begin
					if (search_done)
						state <= SEQ_EARLY;
				end
				SEQ_EARLY: begin
					if (first_q && lag_q > `EARLY_LAG_LIMIT) begin
						state <= SEQ_RESULT;
					end else begin
						state <= SEQ_INTERP;
						interp_start <= 1'b1;
					end
				end
				SEQ_INTERP: begin
					if (interp_done) begin
						if (trial == 3'sd2)
							state <= SEQ_FOLD;
						else
							interp_start <= 1'b1;
					end
				end
				SEQ_FOLD: state <= SEQ_RESULT;
				SEQ_RESULT: begin
					if (result_ready)
						state <= SEQ_IDLE;
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Lag and fraction
	//////////////////////////////

	always_ff @(posedge clock) begin
		case (state)
			SEQ_IDLE: begin
				if (cmd_valid) begin
					t_min_q <= t0_min;
					t_max_q <= t0_max;
					first_q <= first_subframe;
				end
			end
			SEQ_SEARCH: begin
				if (search_done) begin
					center_q <= best_index;
					lag_q <= lag_t'(best_index + t_min_q - `SEARCH_MARGIN);
				end
			end
			SEQ_EARLY: begin
				trial <= -3'sd2;
				best_frac <= '0;
			end
			SEQ_INTERP: begin
				if (interp_done) begin
					// First value seeds, later ones need to be strictly larger
					if (trial == -3'sd2 || interp_value > best_val) begin
						best_val <= interp_value;
						best_frac <= trial;
					end
					trial <= trial + 3'sd1;
				end
			end
			SEQ_FOLD: begin
				if (best_frac == -3'sd2) begin
					best_frac <= 3'sd1;
					lag_q <= lag_q - 8'd1;
				end else if (best_frac == 3'sd2) begin
					best_frac <= -3'sd1;
					lag_q <= lag_q + 8'd1;
				end
			end
			default: ;
		endcase
	end

endmodule

//--- pitch_fr3.sv
module pitch_fr3
	import pitch_fr3_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  cmd_valid,
	input  lag_t  t0_min,
	input  lag_t  t0_max,
	input  logic  first_subframe,
	output logic  cmd_ready,
	input  logic  corr_valid,
	input  corr_t corr_data,
	output logic  corr_ready,
	output logic  result_valid,
	output lag_t  result_lag,
	output frac_t result_frac,
	input  logic  result_ready
);

	logic   load_start;
	index_t load_len;
	logic   load_done;
	logic   search_start;
	index_t first_index;
	index_t last_index;
	logic   search_done;
	index_t best_index;
	logic   interp_start;
	index_t center_index;
	frac_t  frac;
	logic   interp_done;
	corr_t  interp_value;
	index_t rd_addr_a;
	index_t rd_addr_b;
	corr_t  rd_data_a;
	corr_t  rd_data_b;

	corr_buffer u_corr_buffer (
		.clock      (clock),
		.reset      (reset),
		.load_start (load_start),
		.load_len   (load_len),
		.corr_valid (corr_valid),
		.corr_data  (corr_data),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.corr_ready (corr_ready),
		.load_done  (load_done),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b)
	);

	integer_lag_search u_integer_lag_search (
		.clock        (clock),
		.reset        (reset),
		.search_start (search_start),
		.first_index  (first_index),
		.last_index   (last_index),
		.rd_data      (rd_data_a),
		.rd_addr      (rd_addr_a),
		.search_done  (search_done),
		.best_index   (best_index)
	);

	frac_interpolator u_frac_interpolator (
		.clock        (clock),
		.reset        (reset),
		.interp_start (interp_start),
		.center_index (center_index),
		.frac         (frac),
		.rd_data      (rd_data_b),
		.rd_addr      (rd_addr_b),
		.interp_done  (interp_done),
		.interp_value (interp_value)
	);

	lag_sequencer u_lag_sequencer (
		.clock          (clock),
		.reset          (reset),
		.cmd_valid      (cmd_valid),
		.t0_min         (t0_min),
		.t0_max         (t0_max),
		.first_subframe (first_subframe),
		.load_done      (load_done),
		.search_done    (search_done),
		.best_index     (best_index),
		.interp_done    (interp_done),
		.interp_value   (interp_value),
		.result_ready   (result_ready),
		.cmd_ready      (cmd_ready),
		.load_start     (load_start),
		.load_len       (load_len),
		.search_start   (search_start),
		.first_index    (first_index),
		.last_index     (last_index),
		.interp_start   (interp_start),
		.center_index   (center_index),
		.frac           (frac),
		.result_valid   (result_valid),
		.result_lag     (result_lag),
		.result_frac    (result_frac)
	);

endmodule

//--- pitch_fr3_sva.sv
module pitch_fr3_sva
	import pitch_fr3_pkg::*;
(
	input logic  clock,
	input logic  reset,
	input logic  cmd_ready,
	input logic  result_valid,
	input logic  result_ready,
	input lag_t  result_lag,
	input frac_t result_frac
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// Result held with its values until it is taken
	property result_held;
		@(posedge clock) disable iff (reset)
		result_valid && !result_ready |=>
			result_valid && $stable(result_lag) && $stable(result_frac);
	endproperty

	property idle_or_result;
		@(posedge clock) disable iff (reset)
		!(cmd_ready && result_valid);
	endproperty

	// Folded fraction
	property frac_in_range;
		@(posedge clock) disable iff (reset)
		result_valid |-> (result_frac >= -1 && result_frac <= 1);
	endproperty

	result_held_a: assert property (result_held) else begin
		$error("result dropped or changed before result_ready");
		fail_count++;
	end

	idle_or_result_a: assert property (idle_or_result) else begin
		$error("cmd_ready and result_valid high together");
		fail_count++;
	end

	frac_in_range_a: assert property (frac_in_range) else begin
		$error("result_frac outside -1..1");
		fail_count++;
	end

endmodule

bind pitch_fr3 pitch_fr3_sva sva_i (
	.clock        (clock),
	.reset        (reset),
	.cmd_ready    (cmd_ready),
	.result_valid (result_valid),
	.result_ready (result_ready),
	.result_lag   (result_lag),
	.result_frac  (result_frac)
);

//--- pitch_fr3_tb.sv
`include "pitch_fr3_settings.svh"

module pitch_fr3_tb
	import pitch_fr3_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int mem_words = 256;
	localparam int reset_cycles = 4;

	logic  clock;
	logic  reset;
	logic  cmd_valid;
	lag_t  t0_min;
	lag_t  t0_max;
	logic  first_subframe;
	logic  cmd_ready;
	logic  corr_valid;
	corr_t corr_data;
	logic  corr_ready;
	logic  result_valid;
	lag_t  result_lag;
	frac_t result_frac;
	logic  result_ready;

	logic [15:0] cases_mem [mem_words];
	int case_count;
	int pos;
	int errors = 0;
	int passed = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	pitch_fr3 dut_i (
		.clock          (clock),
		.reset          (reset),
		.cmd_valid      (cmd_valid),
		.t0_min         (t0_min),
		.t0_max         (t0_max),
		.first_subframe (first_subframe),
		.cmd_ready      (cmd_ready),
		.corr_valid     (corr_valid),
		.corr_data      (corr_data),
		.corr_ready     (corr_ready),
		.result_valid   (result_valid),
		.result_lag     (result_lag),
		.result_frac    (result_frac),
		.result_ready   (result_ready)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, a case never finished", cycle_count);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	//////////////////////////////
	// Channel drivers
	//////////////////////////////

	task automatic send_command(input lag_t lo, input lag_t hi, input logic first);
		logic accepted;
		@(posedge clock);
		cmd_valid <= 1'b1;
		t0_min <= lo;
		t0_max <= hi;
		first_subframe <= first;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clock);
			accepted = cmd_ready;
			@(posedge clock);
		end
		cmd_valid <= 1'b0;
	endtask

	task automatic stream_correlations(input int start, input int beats, inout int fails);
		int   sent;
		logic accepted;
		logic flagged;
		sent = 0;
		flagged = 1'b0;
		while (sent < beats) begin
			corr_data <= corr_t'(cases_mem[start + sent]);
			// Random stalls on the stream
			corr_valid <= ($urandom % 4) != 0;
			@(negedge clock);
			accepted = corr_valid && corr_ready;
			if (cmd_ready && !flagged) begin
				$display("cmd_ready went high while the correlation stream was loading");
				flagged = 1'b1;
				fails++;
			end
			@(posedge clock);
			if (accepted)
				sent++;
		end
		corr_valid <= 1'b0;
	endtask

	task automatic collect_result(output lag_t lag, output frac_t fr, inout int fails);
		logic taken;
		logic flagged;
		taken = 1'b0;
		flagged = 1'b0;
		while (!taken) begin
			result_ready <= ($urandom % 4) != 0;
			@(negedge clock);
			if (cmd_ready && !flagged) begin
				$display("cmd_ready went high before the result was accepted");
				flagged = 1'b1;
				fails++;
			end
			if (result_valid && result_ready) begin
				taken = 1'b1;
				lag = result_lag;
				fr = result_frac;
			end
			@(posedge clock);
		end
		result_ready <= 1'b0;
	endtask

	//////////////////////////////
	// One case from the data file
	//////////////////////////////

	task automatic run_case(input int number);
		lag_t  lo;
		lag_t  hi;
		logic  first;
		int    beats;
		lag_t  exp_lag;
		frac_t exp_frac;
		lag_t  got_lag;
		frac_t got_frac;
		int    fails;
		lo = lag_t'(cases_mem[pos]);
		hi = lag_t'(cases_mem[pos + 1]);
		first = cases_mem[pos + 2][0];
		beats = int'(hi) - int'(lo) + 2 * `SEARCH_MARGIN + 1;
		exp_lag = lag_t'(cases_mem[pos + 3 + beats]);
		exp_frac = frac_t'(cases_mem[pos + 4 + beats][2:0]);
		fails = 0;
		send_command(lo, hi, first);
		stream_correlations(pos + 3, beats, fails);
		collect_result(got_lag, got_frac, fails);
		if (got_lag !== exp_lag) begin
			$display("mismatch result_lag case %0d: got 0x%h expected 0x%h",
				number, got_lag, exp_lag);
			fails++;
		end
		if (got_frac !== exp_frac) begin
			$display("mismatch result_frac case %0d: got 0x%h expected 0x%h",
				number, got_frac, exp_frac);
			fails++;
		end
		if (got_lag < `PITCH_LAG_MIN || got_lag > `PITCH_LAG_MAX) begin
			$display("case %0d returned lag %0d outside the legal pitch range", number, got_lag);
			fails++;
		end
		if (fails == 0)
			passed++;
		errors += fails;
		$display("case %0d %s: t0 %0d..%0d first %0d -> lag %0d frac %0d", number,
			(fails == 0) ? "ok" : "failed", lo, hi, first, got_lag, got_frac);
		pos = pos + 5 + beats;
	endtask

	initial begin
		int seed_value;
		int n;
		int p;
		int range_len;
		seed_value = $urandom(32'he1ae9fb7);
		reset = 1'b1;
		cmd_valid = 1'b0;
		t0_min = '0;
		t0_max = '0;
		first_subframe = 1'b0;
		corr_valid = 1'b0;
		corr_data = '0;
		result_ready = 1'b0;
		$readmemh("pitch_fr3_cases.txt", cases_mem);
		case_count = int'(cases_mem[0]);

		// Budget per case from its range length
		cycle_limit = reset_cycles + 10;
		p = 1;
		for (n = 0; n < case_count; n++) begin
			range_len = int'(cases_mem[p + 1]) - int'(cases_mem[p]) + 1;
			cycle_limit += (range_len + 8) * 2 + 5 * 15 + 50;
			p += range_len + 2 * `SEARCH_MARGIN + 5;
		end

		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;

		// Idle outputs once reset is released
		@(negedge clock);
		if (cmd_ready !== 1'b1) begin
			$display("mismatch cmd_ready after reset: got 0x%h expected 0x1", cmd_ready);
			errors++;
		end
		if (corr_ready !== 1'b0) begin
			$display("mismatch corr_ready after reset: got 0x%h expected 0x0", corr_ready);
			errors++;
		end
		if (result_valid !== 1'b0) begin
			$display("mismatch result_valid after reset: got 0x%h expected 0x0", result_valid);
			errors++;
		end

		if (case_count == 0) begin
			$display("no test cases were read from the data file");
			errors++;
		end
		pos = 1;
		for (n = 0; n < case_count; n++)
			run_case(n);
		@(posedge clock);
		errors += dut_i.sva_i.fail_count;
		$display("%0d cases, %0d passed, %0d failed, %0d errors",
			case_count, passed, case_count - passed, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- pitch_fr3_cases.txt
// Count of cases, then per case: t0_min t0_max first_subframe,
// correlations for lags t0_min-4..t0_max+4, expected lag, expected fraction (7 is -1)
09
// Early exit in the first subframe, peak at lag 85
55 57 1 0400 0800 0c00 1000 6000 2000 1800 0800 0400 0200 0100 55 0
// Ties select the later lag, larger margin values are ignored
64 66 1 0100 7fff 0200 0300 5000 4000 5000 7000 0100 0100 0100 66 0
5a 5c 1 0000 0000 0000 0000 3000 3000 3000 0000 0000 0000 0000 5c 0
// Refinement at the early exit limit and at the lowest lags
54 54 1 0000 0000 0000 0000 4000 0000 0000 0000 0000 54 0
14 16 1 0000 0000 0000 0000 0000 0000 4000 0000 0000 0000 0000 16 0
// Fractions +1 and -1
28 2a 0 0000 0000 0000 0000 0000 4000 3000 0000 0000 0000 0000 29 1
3b 3d 0 0000 0000 0000 0000 3000 4000 0000 0000 0000 0000 0000 3c 7
// Folding of -2 and +2
46 46 0 0000 0000 0000 4000 3000 0000 0000 0000 0000 45 1
78 78 0 0000 0000 0000 0000 3000 4000 0000 0000 0000 79 7

//--- pitch_fr3.f
+incdir+.
pitch_fr3_pkg.sv
corr_buffer.sv
integer_lag_search.sv
frac_interpolator.sv
lag_sequencer.sv
pitch_fr3.sv
pitch_fr3_sva.sv
pitch_fr3_tb.sv
